/* mipsPkg.sv */
package mipsPkg;

	//////////////////////////////
	// basic types
	//////////////////////////////

	typedef logic [31:0] dataT;    // data, addresses and instructions
	typedef logic [4:0]  regAddrT; // register number

	localparam dataT nopInstr = '0; // sll $0,$0,0 pattern, retires nothing

	//////////////////////////////
	// instruction fields
	//////////////////////////////

	typedef enum logic [5:0]
	{
		opRtype = 6'b000000,
		opBeq   = 6'b000100,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeE;

	typedef enum logic [5:0]
	{
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} functE;

	//////////////////////////////
	// datapath selects
	//////////////////////////////

	typedef enum logic [2:0]
	{
		aluAnd = 3'd0,
		aluOr  = 3'd1,
		aluAdd = 3'd2,
		aluSub = 3'd6,
		aluSlt = 3'd7 // signed compare
	} aluOpE;

	typedef enum logic [1:0]
	{
		fwdReg   = 2'b00, // value read in decode
		fwdMemWb = 2'b01, // write-back value
		fwdExMem = 2'b10  // result one stage ahead
	} fwdSelE;

endpackage

/* regFile.sv */
`timescale 1ns/1ps

module regFile import mipsPkg::*;
(
	input  logic    Clk,
	input  logic    arstN,
	input  regAddrT rdAddrA,
	input  regAddrT rdAddrB,
	input  logic    wrEn,
	input  regAddrT wrAddr,
	input  dataT    wrData,
	output dataT    rdDataA,
	output dataT    rdDataB
);

	dataT regs [32];

	// write-through so decode sees the value retiring this cycle
	function automatic dataT readPort(regAddrT addr);
		if (addr == '0)
			return '0;                 // $zero is hard wired
		else if (wrEn && wrAddr == addr)
			return wrData;             // bypass the write
		else
			return regs[addr];
	endfunction

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn && wrAddr != '0)
			regs[wrAddr] <= wrData;
	end

	assign rdDataA = readPort(rdAddrA);
	assign rdDataB = readPort(rdAddrB);

	// write-back filters $zero before it reaches the write port
	noZeroWrite: assert property (@(posedge Clk) disable iff (!arstN)
		wrEn |-> wrAddr != '0);

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*;
(
	input  regAddrT rs,
	input  regAddrT rt,
	input  logic    isBranch,
	input  regAddrT idExRt,
	input  regAddrT idExDest,
	input  logic    idExMemRead,
	input  logic    idExRegWrite,
	input  regAddrT exMemDest,
	input  logic    exMemMemRead,
	output logic    stall
);

	logic loadUse;
	logic rsPending;
	logic rtPending;

	// load in EX, its data is not ready before MEM/WB
	assign loadUse = idExMemRead && idExRt != '0 && (idExRt == rs || idExRt == rt);

	// beq compares in decode so it needs both operands settled
	assign rsPending = rs != '0 &&
		((idExRegWrite && idExDest == rs) || (exMemMemRead && exMemDest == rs));
	assign rtPending = rt != '0 &&
		((idExRegWrite && idExDest == rt) || (exMemMemRead && exMemDest == rt));

	assign stall = loadUse || (isBranch && (rsPending || rtPending));

endmodule

/* fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import mipsPkg::*;
#(
	parameter dataT ResetPc = '0
)
(
	input  logic Clk,
	input  logic arstN,
	input  dataT imemData,
	input  logic stall,
	input  logic branchTaken,
	input  dataT branchTarget,
	output dataT imemAddr,
	output dataT ifIdInstr,
	output dataT ifIdPcPlus4
);

	dataT pc;
	dataT pcPlus4;

	assign pcPlus4  = pc + 32'd4;
	assign imemAddr = pc; // memory answers in the same cycle

	//////////////////////////////
	// PC and IF/ID
	//////////////////////////////

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc          <= ResetPc;
			ifIdInstr   <= nopInstr;
			ifIdPcPlus4 <= '0;
		end
		else if (branchTaken)
		begin
			pc        <= branchTarget; // redirect
			ifIdInstr <= nopInstr;     // squash the wrong-path fetch
		end
		else if (!stall)
		begin
			pc          <= pcPlus4;
			ifIdInstr   <= imemData;
			ifIdPcPlus4 <= pcPlus4;
		end
	end

	// decode must resolve its own hazards before it may redirect
	noRedirectInStall: assert property (@(posedge Clk) disable iff (!arstN)
		!(stall && branchTaken));

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import mipsPkg::*;
(
	input  logic    Clk,
	input  logic    arstN,
	input  dataT    ifIdInstr,
	input  dataT    ifIdPcPlus4,
	input  logic    wbEn,
	input  regAddrT wbReg,
	input  dataT    wbData,
	input  regAddrT exMemDest,
	input  logic    exMemMemRead,
	input  logic    exMemRegWrite,
	output logic    stall,
	output logic    branchTaken,
	output dataT    branchTarget,
	output regAddrT idExRs,
	output regAddrT idExRt,
	output regAddrT idExRd,
	output dataT    idExA,
	output dataT    idExB,
	output dataT    idExImm,
	output logic    idExRegWrite,
	output logic    idExMemRead,
	output logic    idExMemWrite,
	output logic    idExMemToReg,
	output logic    idExRegDst,
	output opcodeE  idExAluOp
);

	regAddrT rs;
	regAddrT rt;
	dataT    rdDataA;
	dataT    rdDataB;
	dataT    imm;
	regAddrT idExDest;
	logic    exMemPending;

	logic   isBranch;
	logic   regWrite;
	logic   memRead;
	logic   memWrite;
	logic   memToReg;
	logic   regDst;
	opcodeE aluOp;

	assign rs  = ifIdInstr[25:21];
	assign rt  = ifIdInstr[20:16];
	assign imm = {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

	regFile regFile_i
	(
		.Clk     (Clk),
		.arstN   (arstN),
		.rdAddrA (rs),
		.rdAddrB (rt),
		.wrEn    (wbEn),
		.wrAddr  (wbReg),
		.wrData  (wbData),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	//////////////////////////////
	// control decode
	//////////////////////////////

	always_comb
	begin
		isBranch = 1'b0;
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		regDst   = 1'b0;
		aluOp    = opRtype;
		case (ifIdInstr[31:26])
			opRtype:
			begin
				regWrite = 1'b1;
				regDst   = 1'b1; // rd
			end
			opLw:
			begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
				aluOp    = opLw;
			end
			opSw:
			begin
				memWrite = 1'b1;
				aluOp    = opSw;
			end
			opBeq:
				isBranch = 1'b1;
			default: ; // unknown opcode retires as a no-op
		endcase
	end

	// the R-type result in MEM is not bypassed to decode either, so any writer there blocks beq
	assign exMemPending = exMemRegWrite || exMemMemRead;
	assign idExDest     = idExRegDst ? idExRd : idExRt;

	hazardUnit hazardUnit_i
	(
		.rs           (rs),
		.rt           (rt),
		.isBranch     (isBranch),
		.idExRt       (idExRt),
		.idExDest     (idExDest),
		.idExMemRead  (idExMemRead),
		.idExRegWrite (idExRegWrite),
		.exMemDest    (exMemDest),
		.exMemMemRead (exMemPending),
		.stall        (stall)
	);

	assign branchTarget = ifIdPcPlus4 + (imm << 2);
	assign branchTaken  = isBranch && (rdDataA == rdDataB) && !stall;

	//////////////////////////////
	// ID/EX
	//////////////////////////////

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			idExRegWrite <= 1'b0;
			idExMemRead  <= 1'b0;
			idExMemWrite <= 1'b0;
			idExMemToReg <= 1'b0;
			idExRegDst   <= 1'b0;
			idExAluOp    <= opRtype;
			idExRs       <= '0;
			idExRt       <= '0;
			idExRd       <= '0;
		end
		else
		begin
			idExRegWrite <= regWrite && !stall; // bubble on stall
			idExMemRead  <= memRead && !stall;
			idExMemWrite <= memWrite && !stall;
			idExMemToReg <= memToReg;
			idExRegDst   <= regDst;
			idExAluOp    <= aluOp;
			idExRs       <= rs;
			idExRt       <= rt;
			idExRd       <= ifIdInstr[15:11];
		end
	end

	always_ff @(posedge Clk)
	begin
		idExA   <= rdDataA;
		idExB   <= rdDataB;
		idExImm <= imm; // low bits carry funct
	end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage import mipsPkg::*;
(
	input  logic    Clk,
	input  logic    arstN,
	input  regAddrT idExRs,
	input  regAddrT idExRt,
	input  regAddrT idExRd,
	input  dataT    idExA,
	input  dataT    idExB,
	input  dataT    idExImm,
	input  logic    idExRegWrite,
	input  logic    idExMemRead,
	input  logic    idExMemWrite,
	input  logic    idExMemToReg,
	input  logic    idExRegDst,
	input  opcodeE  idExAluOp,
	input  logic    wbEn,
	input  regAddrT wbReg,
	input  dataT    wbData,
	output dataT    exMemResult,
	output dataT    exMemStoreData,
	output regAddrT exMemDest,
	output logic    exMemRegWrite,
	output logic    exMemMemRead,
	output logic    exMemMemWrite,
	output logic    exMemMemToReg
);

	fwdSelE fwdA;
	fwdSelE fwdB;
	dataT   opA;
	dataT   opBReg;
	dataT   opB;
	dataT   aluResult;
	aluOpE  aluOp;
	logic   functValid;
	logic   useImm;
	regAddrT dest;

	//////////////////////////////
	// forwarding
	//////////////////////////////

	// younger result wins, wbEn already excludes $zero
	function automatic fwdSelE fwdFor(regAddrT src);
		if (exMemRegWrite && exMemDest != '0 && exMemDest == src)
			return fwdExMem;
		else if (wbEn && wbReg == src)
			return fwdMemWb;
		else
			return fwdReg;
	endfunction

	function automatic dataT pickOperand(fwdSelE sel, dataT regVal);
		case (sel)
			fwdExMem: return exMemResult;
			fwdMemWb: return wbData;
			default:  return regVal;
		endcase
	endfunction

	assign fwdA   = fwdFor(idExRs);
	assign fwdB   = fwdFor(idExRt);
	assign opA    = pickOperand(fwdA, idExA);
	assign opBReg = pickOperand(fwdB, idExB);

	//////////////////////////////
	// ALU control and ALU
	//////////////////////////////

	always_comb
	begin
		aluOp      = aluAdd;
		functValid = 1'b1;
		if (idExAluOp == opRtype)
		begin
			case (idExImm[5:0])
				fnAdd:   aluOp = aluAdd;
				fnSub:   aluOp = aluSub;
				fnAnd:   aluOp = aluAnd;
				fnOr:    aluOp = aluOr;
				fnSlt:   aluOp = aluSlt;
				default: functValid = 1'b0; // retires as a no-op
			endcase
		end
	end

	assign useImm = (idExAluOp == opLw) || (idExAluOp == opSw); // base + offset
	assign opB    = useImm ? idExImm : opBReg;

	always_comb
	begin
		case (aluOp)
			aluAnd:  aluResult = opA & opB;
			aluOr:   aluResult = opA | opB;
			aluSub:  aluResult = opA - opB;
			aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	assign dest = idExRegDst ? idExRd : idExRt;

	//////////////////////////////
	// EX/MEM
	//////////////////////////////

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			exMemRegWrite <= 1'b0;
			exMemMemRead  <= 1'b0;
			exMemMemWrite <= 1'b0;
			exMemMemToReg <= 1'b0;
			exMemDest     <= '0;
		end
		else
		begin
			exMemRegWrite <= idExRegWrite && functValid;
			exMemMemRead  <= idExMemRead;
			exMemMemWrite <= idExMemWrite;
			exMemMemToReg <= idExMemToReg;
			exMemDest     <= dest;
		end
	end

	always_ff @(posedge Clk)
	begin
		exMemResult    <= aluResult;
		exMemStoreData <= opBReg; // forwarded rt for sw
	end

	// decode never emits an opcode that both loads and stores
	oneMemAccess: assert property (@(posedge Clk) disable iff (!arstN)
		!(exMemMemRead && exMemMemWrite));

endmodule

/* memWbStage.sv */
`timescale 1ns/1ps

module memWbStage import mipsPkg::*;
(
	input  logic    Clk,
	input  logic    arstN,
	input  dataT    exMemResult,
	input  dataT    exMemStoreData,
	input  regAddrT exMemDest,
	input  logic    exMemRegWrite,
	input  logic    exMemMemRead,
	input  logic    exMemMemWrite,
	input  logic    exMemMemToReg,
	input  dataT    dmemRdata,
	output dataT    dmemAddr,
	output dataT    dmemWdata,
	output logic    dmemWe,
	output logic    wbEn,
	output regAddrT wbReg,
	output dataT    wbData
);

	dataT memWbLoadData;
	dataT memWbResult;
	logic memWbMemToReg;

	// data port straight from EX/MEM, write lands on the next edge
	assign dmemAddr  = exMemResult;
	assign dmemWdata = exMemStoreData;
	assign dmemWe    = exMemMemWrite;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wbEn          <= 1'b0;
			wbReg         <= '0;
			memWbMemToReg <= 1'b0;
		end
		else
		begin
			wbEn          <= exMemRegWrite && exMemDest != '0; // $zero never retires
			wbReg         <= exMemDest;
			memWbMemToReg <= exMemMemToReg;
		end
	end

	always_ff @(posedge Clk)
	begin
		memWbResult <= exMemResult;
		if (exMemMemRead)
			memWbLoadData <= dmemRdata; // only sample on a real load
	end

	assign wbData = memWbMemToReg ? memWbLoadData : memWbResult;

endmodule

/* mipsPipeCore.sv */
`timescale 1ns/1ps

module mipsPipeCore import mipsPkg::*;
#(
	parameter dataT ResetPc = '0
)
(
	input  logic    Clk,
	input  logic    arstN,
	output dataT    imemAddr,
	input  dataT    imemData,
	output dataT    dmemAddr,
	output dataT    dmemWdata,
	output logic    dmemWe,
	input  dataT    dmemRdata,
	output logic    wbEn,
	output regAddrT wbReg,
	output dataT    wbData
);

	// IF/ID and redirect
	dataT ifIdInstr;
	dataT ifIdPcPlus4;
	logic stall;
	logic branchTaken;
	dataT branchTarget;

	// ID/EX
	regAddrT idExRs;
	regAddrT idExRt;
	regAddrT idExRd;
	dataT    idExA;
	dataT    idExB;
	dataT    idExImm;
	logic    idExRegWrite;
	logic    idExMemRead;
	logic    idExMemWrite;
	logic    idExMemToReg;
	logic    idExRegDst;
	opcodeE  idExAluOp;

	// EX/MEM
	dataT    exMemResult;
	dataT    exMemStoreData;
	regAddrT exMemDest;
	logic    exMemRegWrite;
	logic    exMemMemRead;
	logic    exMemMemWrite;
	logic    exMemMemToReg;

	fetchStage #(.ResetPc(ResetPc)) fetchStage_i
	(
		.Clk          (Clk),
		.arstN        (arstN),
		.imemData     (imemData),
		.stall        (stall),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.imemAddr     (imemAddr),
		.ifIdInstr    (ifIdInstr),
		.ifIdPcPlus4  (ifIdPcPlus4)
	);

	decodeStage decodeStage_i
	(
		.Clk           (Clk),
		.arstN         (arstN),
		.ifIdInstr     (ifIdInstr),
		.ifIdPcPlus4   (ifIdPcPlus4),
		.wbEn          (wbEn),
		.wbReg         (wbReg),
		.wbData        (wbData),
		.exMemDest     (exMemDest),
		.exMemMemRead  (exMemMemRead),
		.exMemRegWrite (exMemRegWrite),
		.stall         (stall),
		.branchTaken   (branchTaken),
		.branchTarget  (branchTarget),
		.idExRs        (idExRs),
		.idExRt        (idExRt),
		.idExRd        (idExRd),
		.idExA         (idExA),
		.idExB         (idExB),
		.idExImm       (idExImm),
		.idExRegWrite  (idExRegWrite),
		.idExMemRead   (idExMemRead),
		.idExMemWrite  (idExMemWrite),
		.idExMemToReg  (idExMemToReg),
		.idExRegDst    (idExRegDst),
		.idExAluOp     (idExAluOp)
	);

	executeStage executeStage_i
	(
		.Clk            (Clk),
		.arstN          (arstN),
		.idExRs         (idExRs),
		.idExRt         (idExRt),
		.idExRd         (idExRd),
		.idExA          (idExA),
		.idExB          (idExB),
		.idExImm        (idExImm),
		.idExRegWrite   (idExRegWrite),
		.idExMemRead    (idExMemRead),
		.idExMemWrite   (idExMemWrite),
		.idExMemToReg   (idExMemToReg),
		.idExRegDst     (idExRegDst),
		.idExAluOp      (idExAluOp),
		.wbEn           (wbEn),
		.wbReg          (wbReg),
		.wbData         (wbData),
		.exMemResult    (exMemResult),
		.exMemStoreData (exMemStoreData),
		.exMemDest      (exMemDest),
		.exMemRegWrite  (exMemRegWrite),
		.exMemMemRead   (exMemMemRead),
		.exMemMemWrite  (exMemMemWrite),
		.exMemMemToReg  (exMemMemToReg)
	);

	memWbStage memWbStage_i
	(
		.Clk            (Clk),
		.arstN          (arstN),
		.exMemResult    (exMemResult),
		.exMemStoreData (exMemStoreData),
		.exMemDest      (exMemDest),
		.exMemRegWrite  (exMemRegWrite),
		.exMemMemRead   (exMemMemRead),
		.exMemMemWrite  (exMemMemWrite),
		.exMemMemToReg  (exMemMemToReg),
		.dmemRdata      (dmemRdata),
		.dmemAddr       (dmemAddr),
		.dmemWdata      (dmemWdata),
		.dmemWe         (dmemWe),
		.wbEn           (wbEn),
		.wbReg          (wbReg),
		.wbData         (wbData)
	);

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock
#(
	parameter int ResetCycles = 2
)
(
	output logic Clk,
	output logic arstN
);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk; // 4 ns period
	end

	initial
	begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge Clk);
		arstN <= 1'b1; // release on a rising edge
	end

endmodule

/* mipsPipeCoreTb.sv */
`timescale 1ns/1ps

module mipsPipeCoreTb import mipsPkg::*;
();

	localparam int   ProgLen   = 64;
	localparam int   DataWords = 64;
	localparam int   RunCycles = 4 * ProgLen + 40; // worst case stalls plus drain
	localparam dataT ResetPc   = '0;

	logic    Clk;
	logic    arstN;
	dataT    imemAddr;
	dataT    imemData;
	dataT    dmemAddr;
	dataT    dmemWdata;
	logic    dmemWe;
	dataT    dmemRdata;
	logic    wbEn;
	regAddrT wbReg;
	dataT    wbData;

	dataT progArr [ProgLen];
	dataT dmemArr [DataWords];
	dataT initMem [DataWords]; // memory image before the first store

	regAddrT expWbReg  [$];
	dataT    expWbData [$];
	dataT    expStAddr [$];
	dataT    expStData [$];

	integer seed;
	int     cycleCount  = 0;
	int     valueErrors = 0;
	int     eventErrors = 0;
	int     resetErrors = 0;

	tbClock clock_i
	(
		.Clk   (Clk),
		.arstN (arstN)
	);

	mipsPipeCore #(.ResetPc(ResetPc)) dut_i
	(
		.Clk       (Clk),
		.arstN     (arstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.dmemAddr  (dmemAddr),
		.dmemWdata (dmemWdata),
		.dmemWe    (dmemWe),
		.dmemRdata (dmemRdata),
		.wbEn      (wbEn),
		.wbReg     (wbReg),
		.wbData    (wbData)
	);

	//////////////////////////////
	// memory models
	//////////////////////////////

	// fetches past the program see no-ops
	assign imemData  = (imemAddr < dataT'(ProgLen * 4)) ? progArr[imemAddr[7:2]] : nopInstr;
	assign dmemRdata = dmemArr[dmemAddr[7:2]];

	always @(posedge Clk)
	begin
		if (arstN && dmemWe)
			dmemArr[dmemAddr[7:2]] <= dmemWdata;
	end

	always @(posedge Clk)
	begin
		if (arstN)
			cycleCount <= cycleCount + 1;
	end

	//////////////////////////////
	// stimulus and reference model
	//////////////////////////////

	task automatic fillDataMem();
		dataT word;
		int   i;
		for (i = 0; i < DataWords; i++)
		begin
			word       = $random(seed);
			dmemArr[i] <= word;
			initMem[i] = word;
		end
	endtask

	task automatic buildProgram();
		dataT    r;
		int      pick;
		int      i;
		functE   fn;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		for (i = 0; i < ProgLen; i++)
		begin
			r    = $random(seed);
			pick = int'(r[7:0]) % 20;
			rs   = {2'b00, r[13:11]}; // registers 0 to 7 only
			rt   = {2'b00, r[16:14]};
			rd   = {2'b00, r[19:17]};
			case (r[10:8])
				3'd0:    fn = fnAdd;
				3'd1:    fn = fnSub;
				3'd2:    fn = fnAnd;
				3'd3:    fn = fnOr;
				3'd4:    fn = fnSlt;
				3'd5:    fn = fnSub;
				3'd6:    fn = fnSlt;
				default: fn = fnAdd;
			endcase
			if (pick < 9)
				progArr[i] = {opRtype, rs, rt, rd, 5'd0, fn};
			else if (pick < 13)
				progArr[i] = {opLw, 5'd0, rt, 8'd0, r[25:20], 2'b00}; // word offset 0..252
			else if (pick < 16)
				progArr[i] = {opSw, 5'd0, rt, 8'd0, r[25:20], 2'b00};
			else
				progArr[i] = {opBeq, rs, rt, 14'd0, r[27:26]}; // forward 0..3
		end
	endtask

	// executes in program order, no timing
	task automatic runModel();
		dataT    regs [32];
		dataT    mem [DataWords];
		dataT    instr;
		dataT    a;
		dataT    b;
		dataT    res;
		dataT    offs;
		dataT    addr;
		regAddrT rd;
		logic    valid;
		int      pc;
		int      i;
		for (i = 0; i < 32; i++)
			regs[i] = '0;
		for (i = 0; i < DataWords; i++)
			mem[i] = initMem[i];
		pc = 0;
		while (pc < ProgLen)
		begin
			instr = progArr[pc];
			a     = regs[instr[25:21]];
			b     = regs[instr[20:16]];
			offs  = {{16{instr[15]}}, instr[15:0]};
			addr  = a + offs;
			pc++;
			case (instr[31:26])
				opRtype:
				begin
					valid = 1'b1;
					rd    = instr[15:11];
					case (instr[5:0])
						fnAdd:   res = a + b;
						fnSub:   res = a - b;
						fnAnd:   res = a & b;
						fnOr:    res = a | b;
						fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: valid = 1'b0;
					endcase
					if (valid && rd != '0)
					begin
						regs[rd] = res;
						expWbReg.push_back(rd);
						expWbData.push_back(res);
					end
				end
				opLw:
				begin
					rd = instr[20:16];
					if (rd != '0)
					begin
						regs[rd] = mem[addr[7:2]];
						expWbReg.push_back(rd);
						expWbData.push_back(mem[addr[7:2]]);
					end
				end
				opSw:
				begin
					mem[addr[7:2]] = b;
					expStAddr.push_back(addr);
					expStData.push_back(b);
				end
				opBeq:
				begin
					if (a == b)
						pc = pc + int'($signed(offs)); // relative to the next word
				end
				default: ;
			endcase
		end
	endtask

	//////////////////////////////
	// checkers
	//////////////////////////////

	task automatic checkResetState(logic wbEnNow, logic dmemWeNow, dataT pcNow);
		if (wbEnNow !== 1'b0)
		begin
			$display("FAIL wbEn in reset: got %h expected 0", wbEnNow);
			resetErrors++;
		end
		if (dmemWeNow !== 1'b0)
		begin
			$display("FAIL dmemWe in reset: got %h expected 0", dmemWeNow);
			resetErrors++;
		end
		if (pcNow !== ResetPc)
		begin
			$display("FAIL imemAddr in reset: got %h expected %h", pcNow, ResetPc);
			resetErrors++;
		end
	endtask

	task automatic checkWb(regAddrT dest, dataT data);
		regAddrT expReg;
		dataT    expData;
		if (expWbReg.size() == 0)
		begin
			$display("register write to r%0d arrived after the program's last write", dest);
			eventErrors++;
		end
		else
		begin
			expReg  = expWbReg.pop_front();
			expData = expWbData.pop_front();
			if (dest !== expReg)
			begin
				$display("FAIL wbReg: got %h expected %h", dest, expReg);
				valueErrors++;
			end
			if (data !== expData)
			begin
				$display("FAIL wbData: got %h expected %h", data, expData);
				valueErrors++;
			end
		end
	endtask

	task automatic checkStore(dataT addr, dataT data);
		dataT expAddr;
		dataT expData;
		if (expStAddr.size() == 0)
		begin
			$display("store to address %h arrived after the program's last store", addr);
			eventErrors++;
		end
		else
		begin
			expAddr = expStAddr.pop_front();
			expData = expStData.pop_front();
			if (addr !== expAddr)
			begin
				$display("FAIL dmemAddr: got %h expected %h", addr, expAddr);
				valueErrors++;
			end
			if (data !== expData)
			begin
				$display("FAIL dmemWdata: got %h expected %h", data, expData);
				valueErrors++;
			end
		end
	endtask

	// mid-cycle sampling, outputs settled
	always @(negedge Clk)
	begin
		if (!arstN || cycleCount == 0)
			checkResetState(wbEn, dmemWe, imemAddr);
		else
		begin
			if (wbEn)
				checkWb(wbReg, wbData);
			if (dmemWe)
				checkStore(dmemAddr, dmemWdata);
		end
	end

	//////////////////////////////
	// run control
	//////////////////////////////

	initial
	begin
		seed = 32'hc6e6_3d73;
		fillDataMem();
		buildProgram();
		runModel();
		$display("program ready: %0d register writes and %0d stores expected",
			expWbReg.size(), expStAddr.size());
		while (cycleCount < RunCycles)
			@(posedge Clk);
		@(negedge Clk);
		if (expWbReg.size() != 0)
		begin
			$display("cycle limit reached with %0d register writes never seen", expWbReg.size());
			eventErrors += expWbReg.size();
		end
		if (expStAddr.size() != 0)
		begin
			$display("cycle limit reached with %0d stores never seen", expStAddr.size());
			eventErrors += expStAddr.size();
		end
		$display("errors: %0d value, %0d event, %0d reset", valueErrors, eventErrors, resetErrors);
		if (valueErrors + eventErrors + resetErrors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* list.f */
mipsPkg.sv
regFile.sv
hazardUnit.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
mipsPipeCore.sv
tbClock.sv
mipsPipeCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mipsPipeCoreTb -f list.f \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/VmipsPipeCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
	exit 0
fi
exit 1
